//--- sim.f
rtl/vreg_pkg.sv
rtl/vreg_wr_mux.sv
rtl/vreg_file.sv
rtl/vreg_hazard_ctrl.sv
rtl/vreg_wb_top.sv
tests/vreg_wb_chk.sv
tests/tb_vreg_wb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the testbench with Verilator and judges the run from sim.log
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ns --top-module tb_vreg_wb -f sim.f > sim.log 2>&1 &&
    ./obj_dir/Vtb_vreg_wb >> sim.log 2>&1 ||
    echo "SIMULATION FAILED" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
exit 0

//--- tests/tb_vreg_wb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the vector write-back stage. It plays the pipelines and the
// issue logic and checks the read port and the pending map against a model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tb_vreg_wb
    import vreg_pkg::*;
();

    localparam int unsigned PIPE_CNT                = 3;
    localparam int unsigned VPORT_WR_CNT            = 2;
    localparam int unsigned PIPE_VPORT_WR[PIPE_CNT] = '{0, 0, 1};
    localparam unit_e       PIPE_UNITS   [PIPE_CNT] = '{UNIT_ALU, UNIT_MUL, UNIT_ELEM};
    localparam int          HIST_D                  = 1 << (PIPE_CNT - 1);
    localparam int          RAND_CYCLES             = 1800;
    localparam int          TIMEOUT_CYCLES          = 2 * (RAND_CYCLES + 200);

    logic                    clk_i = 1'b0;
    logic                    rst_n_i;
    logic     [PIPE_CNT-1:0] pipe_wr_valid_i;
    vreg_wr_t [PIPE_CNT-1:0] pipe_wr_i;
    logic                    issue_valid_i;
    issue_t                  issue_i;
    logic     [VADDR_W-1:0]  rd_addr_i;
    logic     [VREG_W-1:0]   rd_data_o;
    logic     [VREG_CNT-1:0] pending_o;

    logic     [VREG_W-1:0]   exp_regs [VREG_CNT];
    logic     [VREG_CNT-1:0] exp_pending;
    logic     [VREG_CNT-1:0] exp_clr_q;
    logic                    hist_v [PIPE_CNT][HIST_D];
    vreg_wr_t                hist_w [PIPE_CNT][HIST_D];
    logic                    rd_chk_en = 1'b0;
    int                      errors = 0;
    int                      cycle_cnt = 0;
    int                      seed = 32'h30c57f64;

    vreg_wb_top #(
        .PIPE_CNT      (PIPE_CNT),
        .VPORT_WR_CNT  (VPORT_WR_CNT),
        .PIPE_VPORT_WR (PIPE_VPORT_WR),
        .PIPE_UNITS    (PIPE_UNITS)
    ) dut (.*);

    always #2 clk_i = ~clk_i;

    function automatic int rank_on_port(int k);
        int r;
        r = 0;
        for (int j = 0; j < k; j++) begin
            if (PIPE_VPORT_WR[j] == PIPE_VPORT_WR[k]) begin
                r++;
            end
        end
        return r;
    endfunction

    // delay of the copy that pipeline k presents
    // the live input counts as 0 and no write at all as -1
    function automatic int present_delay(int k);
        int d;
        d = pipe_wr_valid_i[k] ? 0 : -1;
        for (int m = 1; m <= rank_on_port(k); m++) begin
            if (hist_v[k][(1 << m) - 2]) begin
                d = (1 << m) - 1;
            end
        end
        return d;
    endfunction

    function automatic int port_winner(int p);
        for (int k = 0; k < PIPE_CNT; k++) begin
            if (PIPE_VPORT_WR[k] == p && present_delay(k) >= 0) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic logic [VREG_CNT-1:0] group_mask(logic [VADDR_W-1:0] addr,
                                                       logic [CLR_CNT_W-1:0] cnt);
        logic [VREG_CNT-1:0] v;
        for (int j = 0; j < VREG_CNT; j++) begin
            v[j] = (j >> cnt) == (int'(addr) >> cnt);
        end
        return v;
    endfunction

    function automatic logic [VREG_CNT-1:0] clear_vec(vreg_wr_t w, unit_e unit);
        logic [VREG_CNT-1:0] v;
        v = '0;
        if (unit == UNIT_ELEM) begin
            v = group_mask(w.addr, w.clr_cnt);
        end else begin
            v[w.addr] = 1'b1;
        end
        return v;
    endfunction

    function automatic logic [VREG_W-1:0] merge_bytes(logic [VREG_W-1:0] old, vreg_wr_t w);
        logic [VREG_W-1:0] v;
        v = old;
        for (int b = 0; b < BE_W; b++) begin
            if (w.be[b]) begin
                v[b*8 +: 8] = w.data[b*8 +: 8];
            end
        end
        return v;
    endfunction

    always @(posedge clk_i) begin : model
        int                  dly;
        int                  win;
        vreg_wr_t            pres [PIPE_CNT];
        logic [VREG_CNT-1:0] clr_next;
        if (!rst_n_i) begin
            exp_pending = '0;
            exp_clr_q   = '0;
            for (int k = 0; k < PIPE_CNT; k++) begin
                for (int i = 0; i < HIST_D; i++) begin
                    hist_v[k][i] = 1'b0;
                end
            end
        end else begin
            clr_next = '0;
            for (int k = 0; k < PIPE_CNT; k++) begin
                dly     = present_delay(k);
                pres[k] = (dly > 0) ? hist_w[k][dly-1] : pipe_wr_i[k];
                if (dly >= 0 && pres[k].clr) begin
                    clr_next |= clear_vec(pres[k], PIPE_UNITS[k]);
                end
            end
            // port 1 is applied after port 0 and wins a shared byte
            for (int p = 0; p < VPORT_WR_CNT; p++) begin
                win = port_winner(p);
                if (win >= 0) begin
                    exp_regs[pres[win].addr] = merge_bytes(exp_regs[pres[win].addr], pres[win]);
                end
            end
            exp_pending = (exp_pending & ~exp_clr_q) |
                          (issue_valid_i ? group_mask(issue_i.dest, issue_i.cnt) : '0);
            exp_clr_q   = clr_next;
            for (int k = 0; k < PIPE_CNT; k++) begin
                for (int i = HIST_D - 1; i > 0; i--) begin
                    hist_v[k][i] = hist_v[k][i-1];
                    hist_w[k][i] = hist_w[k][i-1];
                end
                hist_v[k][0] = pipe_wr_valid_i[k];
                hist_w[k][0] = pipe_wr_i[k];
            end
        end
    end

    task automatic check_value(string name, logic [VREG_W-1:0] exp, logic [VREG_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    always @(negedge clk_i) begin
        if (rst_n_i) begin
            check_value("pending_o", VREG_W'(exp_pending), VREG_W'(pending_o));
            if (rd_chk_en) begin
                check_value("rd_data_o", exp_regs[rd_addr_i], rd_data_o);
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        pipe_wr_valid_i = '0;
        issue_valid_i   = 1'b0;
    endtask

    task automatic put_write(int k, logic [VADDR_W-1:0] addr, logic clr,
                             logic [CLR_CNT_W-1:0] cnt);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        r0 = $random(seed);
        r1 = $random(seed);
        r2 = $random(seed);
        pipe_wr_valid_i[k] = 1'b1;
        pipe_wr_i[k] = '{addr: addr, be: r0[BE_W-1:0], data: {r1, r2}, clr: clr, clr_cnt: cnt};
        rd_addr_i = addr;
    endtask

    task automatic put_issue(logic [VADDR_W-1:0] dest, logic [CLR_CNT_W-1:0] cnt);
        issue_valid_i = 1'b1;
        issue_i       = '{dest: dest, cnt: cnt};
    endtask

    initial begin
        logic [31:0]         r;
        logic [PIPE_CNT-1:0] last_v;
        rst_n_i         = 1'b0;
        pipe_wr_valid_i = '0;
        pipe_wr_i       = '0;
        issue_valid_i   = 1'b0;
        issue_i         = '0;
        rd_addr_i       = '0;
        repeat (10) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        // fill every register so the read port is defined from here on
        for (int i = 0; i < VREG_CNT; i++) begin
            next_cycle();
            put_write(2, VADDR_W'(i), 1'b0, '0);
            pipe_wr_i[2].be = '1;
        end
        next_cycle();
        rd_chk_en = 1'b1;
        for (int i = 0; i < 12; i++) begin
            r = $random(seed);
            next_cycle();
            put_write(i % 3, r[4:0], 1'b0, '0);
            repeat (2) next_cycle();
        end
        // pipeline 1 loses port 0 and lands through replay while pipeline 2 runs alongside
        for (int i = 0; i < 12; i++) begin
            r = $random(seed);
            next_cycle();
            put_write(0, r[4:0], 1'b0, '0);
            put_write(1, r[4:0] ^ 5'h10, 1'b0, '0);
            if (i % 2 == 1) begin
                put_write(2, r[9:5], 1'b0, '0);
            end
            repeat (3) next_cycle();
            rd_addr_i = r[4:0];
        end
        for (int c = 0; c < 4; c++) begin
            r = $random(seed);
            next_cycle();
            put_issue(r[4:0], CLR_CNT_W'(c));
            next_cycle();
            put_write(c % 2, r[4:0], 1'b1, 2'd3);
            repeat (3) next_cycle();
        end
        // the clear meets the second issue at the scoreboard one cycle after it is presented
        for (int c = 0; c < 4; c++) begin
            r = $random(seed);
            next_cycle();
            put_issue(r[4:0], 2'd3);
            next_cycle();
            put_write(2, r[4:0], 1'b1, CLR_CNT_W'(c));
            next_cycle();
            put_issue(r[4:0], '0);
            repeat (3) next_cycle();
        end
        for (int i = 0; i < RAND_CYCLES; i++) begin
            last_v = pipe_wr_valid_i;
            next_cycle();
            for (int k = 0; k < PIPE_CNT; k++) begin
                r = $random(seed);
                // port 0 pipelines never write on two consecutive cycles
                if (r[1:0] == 2'b00 && !(last_v[k] && k < 2)) begin
                    put_write(k, r[6:2], r[7], r[9:8]);
                end
            end
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                put_issue(r[6:2], r[8:7]);
            end
            rd_addr_i = r[13:9];
        end
        repeat (4) next_cycle();
        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/vreg_wb_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on the write-back top level, bound into it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module vreg_wb_chk import vreg_pkg::*; #(
    parameter int unsigned VPORT_WR_CNT = 2
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             issue_valid_i,
    input  issue_t                           issue_i,
    input  logic          [VADDR_W-1:0]      rd_addr_i,
    input  logic          [VREG_W-1:0]       rd_data_o,
    input  logic          [VREG_CNT-1:0]     pending_o,
    input  logic          [VPORT_WR_CNT-1:0] port_wr_en_i,
    input  vreg_port_wr_t [VPORT_WR_CNT-1:0] port_wr_i
);

    logic [BE_W-1:0]    written_q [VREG_CNT];
    logic [VADDR_W-1:0] dest_q;
    logic [VREG_W-1:0]  known;

    always_ff @(posedge clk_i) begin
        dest_q <= issue_i.dest;
        if (!rst_n_i) begin
            for (int r = 0; r < VREG_CNT; r++) begin
                written_q[r] <= '0;
            end
        end else begin
            for (int p = 0; p < VPORT_WR_CNT; p++) begin
                if (port_wr_en_i[p]) begin
                    written_q[port_wr_i[p].addr] <= written_q[port_wr_i[p].addr] | port_wr_i[p].be;
                end
            end
        end
    end

    // only bytes written since reset must read as known
    always_comb begin
        for (int b = 0; b < BE_W; b++) begin
            known[b*8 +: 8] = {8{written_q[rd_addr_i][b]}};
        end
    end

    a_reset_clears: assert property (@(posedge clk_i) !rst_n_i |=> pending_o == '0)
        else $error("pending map not cleared after reset");

    a_issue_sets: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_valid_i |=> pending_o[dest_q])
        else $error("issued register not pending one cycle later");

    a_read_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(rd_data_o & known))
        else $error("read data unknown in a written byte");

endmodule

bind vreg_wb_top vreg_wb_chk #(
    .VPORT_WR_CNT (VPORT_WR_CNT)
) u_chk (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_i       (issue_i),
    .rd_addr_i     (rd_addr_i),
    .rd_data_o     (rd_data_o),
    .pending_o     (pending_o),
    .port_wr_en_i  (port_wr_en),
    .port_wr_i     (port_wr)
);

`default_nettype wire

//--- rtl/vreg_wb_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write-back stage of the vector coprocessor. Pipelines write through
// the port multiplexer into the register file, and the scoreboard
// tracks which registers still wait for a write.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module vreg_wb_top import vreg_pkg::*; #(
    parameter int unsigned PIPE_CNT                = 3,
    parameter int unsigned VPORT_WR_CNT            = 2,
    parameter int unsigned PIPE_VPORT_WR[PIPE_CNT] = '{0, 0, 1},
    parameter unit_e       PIPE_UNITS   [PIPE_CNT] = '{UNIT_ALU, UNIT_MUL, UNIT_ELEM}
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic     [PIPE_CNT-1:0]       pipe_wr_valid_i,
    input  vreg_wr_t [PIPE_CNT-1:0]       pipe_wr_i,
    input  logic                          issue_valid_i,
    input  issue_t                        issue_i,
    input  logic     [VADDR_W-1:0]        rd_addr_i,
    output logic     [VREG_W-1:0]         rd_data_o,
    output logic     [VREG_CNT-1:0]       pending_o
);

    logic          [VPORT_WR_CNT-1:0]           port_wr_en;
    vreg_port_wr_t [VPORT_WR_CNT-1:0]           port_wr;
    logic          [PIPE_CNT-1:0][VREG_CNT-1:0] pipe_clr_vec;

    vreg_wr_mux #(
        .PIPE_CNT      (PIPE_CNT),
        .VPORT_WR_CNT  (VPORT_WR_CNT),
        .PIPE_VPORT_WR (PIPE_VPORT_WR),
        .PIPE_UNITS    (PIPE_UNITS)
    ) u_wr_mux (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .pipe_wr_valid_i (pipe_wr_valid_i),
        .pipe_wr_i       (pipe_wr_i),
        .port_wr_en_o    (port_wr_en),
        .port_wr_o       (port_wr),
        .pipe_clr_vec_o  (pipe_clr_vec)
    );

    vreg_file #(
        .VPORT_WR_CNT (VPORT_WR_CNT)
    ) u_file (
        .clk_i        (clk_i),
        .port_wr_en_i (port_wr_en),
        .port_wr_i    (port_wr),
        .rd_addr_i    (rd_addr_i),
        .rd_data_o    (rd_data_o)
    );

    vreg_hazard_ctrl #(
        .PIPE_CNT (PIPE_CNT)
    ) u_hazard_ctrl (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .pipe_clr_vec_i (pipe_clr_vec),
        .pending_o      (pending_o)
    );

endmodule

`default_nettype wire

//--- rtl/vreg_hazard_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scoreboard of vector registers with writes outstanding. Issue sets a
// register group, the write multiplexer's clear vectors release it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module vreg_hazard_ctrl import vreg_pkg::*; #(
    parameter int unsigned PIPE_CNT = 3
) (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               issue_valid_i,
    input  issue_t                             issue_i,
    input  logic [PIPE_CNT-1:0][VREG_CNT-1:0]  pipe_clr_vec_i,
    output logic [VREG_CNT-1:0]                pending_o
);

    logic [VREG_CNT-1:0] pending_q;
    logic [VREG_CNT-1:0] clr_all;
    logic [VREG_CNT-1:0] set_vec;
    logic [VADDR_W-1:0]  grp_mask;

    always_comb begin
        clr_all = '0;
        for (int i = 0; i < PIPE_CNT; i++) begin
            clr_all |= pipe_clr_vec_i[i];
        end
    end

    // the issued group is the aligned block of 2**cnt registers around dest
    assign grp_mask = {VADDR_W{1'b1}} << issue_i.cnt;

    always_comb begin
        set_vec = '0;
        if (issue_valid_i) begin
            for (int j = 0; j < VREG_CNT; j++) begin
                set_vec[j] = (VADDR_W'(j) & grp_mask) == (issue_i.dest & grp_mask);
            end
        end
    end

    // a register issued and released in the same cycle stays pending
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~clr_all) | set_vec;
        end
    end

    assign pending_o = pending_q;

endmodule

`default_nettype wire

//--- rtl/vreg_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector register file with byte-enable write ports and one
// combinational read port.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module vreg_file import vreg_pkg::*; #(
    parameter int unsigned VPORT_WR_CNT = 2
) (
    input  logic                                 clk_i,
    input  logic          [VPORT_WR_CNT-1:0]     port_wr_en_i,
    input  vreg_port_wr_t [VPORT_WR_CNT-1:0]     port_wr_i,
    input  logic          [VADDR_W-1:0]          rd_addr_i,
    output logic          [VREG_W-1:0]           rd_data_o
);

    logic [VREG_W-1:0] regs_q [VREG_CNT];

    // ports are visited in ascending order, so a higher port wins a byte
    // that two ports write in the same cycle
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < VPORT_WR_CNT; p++) begin
            if (port_wr_en_i[p]) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (port_wr_i[p].be[b]) begin
                        regs_q[port_wr_i[p].addr][b*8 +: 8] <= port_wr_i[p].data[b*8 +: 8];
                    end
                end
            end
        end
    end

    assign rd_data_o = regs_q[rd_addr_i];

endmodule

`default_nettype wire

//--- rtl/vreg_wr_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Maps pipeline writes onto register-file write ports by fixed priority.
// Losing writes are replayed from a delay buffer, and every presented
// write produces a registered hazard-clear vector for the scoreboard.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module vreg_wr_mux import vreg_pkg::*; #(
    parameter int unsigned PIPE_CNT                = 3,
    parameter int unsigned VPORT_WR_CNT            = 2,
    parameter int unsigned PIPE_VPORT_WR[PIPE_CNT] = '{0, 0, 1},
    parameter unit_e       PIPE_UNITS   [PIPE_CNT] = '{UNIT_ALU, UNIT_MUL, UNIT_ELEM}
) (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    input  logic          [PIPE_CNT-1:0]            pipe_wr_valid_i,
    input  vreg_wr_t      [PIPE_CNT-1:0]            pipe_wr_i,
    output logic          [VPORT_WR_CNT-1:0]        port_wr_en_o,
    output vreg_port_wr_t [VPORT_WR_CNT-1:0]        port_wr_o,
    output logic          [PIPE_CNT-1:0][VREG_CNT-1:0] pipe_clr_vec_o
);

    // number of lower-index pipelines competing for the same port
    function automatic int unsigned lower_sharers(int unsigned idx);
        int unsigned cnt;
        cnt = 0;
        for (int unsigned k = 0; k < idx; k++) begin
            if (PIPE_VPORT_WR[k] == PIPE_VPORT_WR[idx]) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    logic     [PIPE_CNT-1:0] sel_valid;
    vreg_wr_t [PIPE_CNT-1:0] sel_wr;

    for (genvar i = 0; i < PIPE_CNT; i++) begin : g_pipe
        localparam int unsigned MAX_DELAY = (1 << lower_sharers(i)) - 1;
        localparam bit          BULK_CLR  = (PIPE_UNITS[i] == UNIT_ELEM);

        logic                rp_valid;
        vreg_wr_t            rp_wr;
        logic [VADDR_W-1:0]  clr_mask;
        logic [VREG_CNT-1:0] clr_d;
        logic [VREG_CNT-1:0] clr_q;

        if (MAX_DELAY > 0) begin : g_replay
            logic     [MAX_DELAY-1:0] buf_en_q;
            vreg_wr_t                 buf_q [MAX_DELAY];

            always_ff @(posedge clk_i) begin
                if (!rst_n_i) begin
                    buf_en_q <= '0;
                end else begin
                    buf_en_q <= MAX_DELAY'({buf_en_q, pipe_wr_valid_i[i]});
                end
            end

            always_ff @(posedge clk_i) begin
                buf_q[0] <= pipe_wr_i[i];
                for (int j = 1; j < MAX_DELAY; j++) begin
                    buf_q[j] <= buf_q[j-1];
                end
            end

            // entries at delays 1, 3, 7 ... take over from the live input
            always_comb begin
                rp_valid = pipe_wr_valid_i[i];
                rp_wr    = pipe_wr_i[i];
                for (int j = 0; j < MAX_DELAY; j++) begin
                    if ((((j + 1) & (j + 2)) == 0) && buf_en_q[j]) begin
                        rp_valid = 1'b1;
                        rp_wr    = buf_q[j];
                    end
                end
            end
        end else begin : g_direct
            // nobody outranks this pipeline on its port, so it never replays
            assign rp_valid = pipe_wr_valid_i[i];
            assign rp_wr    = pipe_wr_i[i];
        end

        assign sel_valid[i] = rp_valid;
        assign sel_wr[i]    = rp_wr;

        assign clr_mask = {VADDR_W{1'b1}} << rp_wr.clr_cnt;

        always_comb begin
            clr_d = '0;
            if (rp_valid && rp_wr.clr) begin
                if (BULK_CLR) begin
                    for (int j = 0; j < VREG_CNT; j++) begin
                        clr_d[j] = (VADDR_W'(j) & clr_mask) == (rp_wr.addr & clr_mask);
                    end
                end else begin
                    clr_d[rp_wr.addr] = 1'b1;
                end
            end
        end

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                clr_q <= '0;
            end else begin
                clr_q <= clr_d;
            end
        end

        assign pipe_clr_vec_o[i] = clr_q;
    end

    // walk from the highest index down so the lowest presenting pipeline wins
    always_comb begin
        port_wr_en_o = '0;
        port_wr_o    = '0;
        for (int p = 0; p < VPORT_WR_CNT; p++) begin
            for (int k = PIPE_CNT - 1; k >= 0; k--) begin
                if ((PIPE_VPORT_WR[k] == p) && sel_valid[k]) begin
                    port_wr_en_o[p]   = 1'b1;
                    port_wr_o[p].addr = sel_wr[k].addr;
                    port_wr_o[p].be   = sel_wr[k].be;
                    port_wr_o[p].data = sel_wr[k].data;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/vreg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register geometry and shared types of the vector write-back stage.
// Modules take it in by a wildcard import in their header.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package vreg_pkg;

    localparam int unsigned VADDR_W   = 5;
    localparam int unsigned VREG_CNT  = 1 << VADDR_W;
    localparam int unsigned VREG_W    = 64;
    localparam int unsigned BE_W      = VREG_W / 8;
    // a clear group spans 2**clr_cnt registers
    localparam int unsigned CLR_CNT_W = 2;

    // pipeline kinds, only UNIT_ELEM clears hazards group-wise
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_LSU,
        UNIT_ELEM
    } unit_e;

    typedef struct packed {
        logic [VADDR_W-1:0]   addr;
        logic [BE_W-1:0]      be;
        logic [VREG_W-1:0]    data;
        logic                 clr;
        logic [CLR_CNT_W-1:0] clr_cnt;
    } vreg_wr_t;

    typedef struct packed {
        logic [VADDR_W-1:0] addr;
        logic [BE_W-1:0]    be;
        logic [VREG_W-1:0]  data;
    } vreg_port_wr_t;

    typedef struct packed {
        logic [VADDR_W-1:0]   dest;
        logic [CLR_CNT_W-1:0] cnt;
    } issue_t;

endpackage

`default_nettype wire
